// File: harmonics_macros.svh
`ifndef HARMONICS_MACROS_SVH
`define HARMONICS_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// estimator dimensions

// at least 4, so that no read meets a pending write
`define HARMONICS_NUM 26
`define SERIES_NUM 3

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// number format and memory layout

`define SAMPLE_W 18
`define FRAC_BITS 16
`define STATE_AW 9
`define COEF_AW 9
// inputs sit right after the rotation and gain pairs
`define COEF_INPUT_BASE (2 * `HARMONICS_NUM)

// pipeline depths
`define READ_LATENCY 1
`define MAC_DEPTH 2
`define DRAIN_STEPS (`READ_LATENCY + `MAC_DEPTH)

`endif

// File: harmonics_pkg.sv
`include "harmonics_macros.svh"

package harmonics_pkg;

	// state address fields, harmonic in the low bits
	localparam int harmW = $clog2(`HARMONICS_NUM);
	localparam int serW = `STATE_AW - harmW;

	// signed fixed point, FRAC_BITS of fraction
	typedef logic signed [`SAMPLE_W-1:0] sample_t;

	// state {x1, x2}, rotation {cos, sin}, gain {k1, k2} or input {sample, unused}
	typedef struct packed {
		sample_t a;
		sample_t b;
	} pair_t;

	// running sum of the first state components
	typedef logic signed [23:0] acc_t;

	typedef logic [`STATE_AW-1:0] stateAddr_t;
	typedef logic [`COEF_AW-1:0] coefAddr_t;

	typedef enum logic [1:0] {
		opIdle,
		opRotate,
		opError,
		opCorrect
	} macOp_e;

	// one issued step, the write address travels with it
	typedef struct packed {
		macOp_e op;
		stateAddr_t wrAddr;
	} microOp_t;

	// {series, harmonic} location of one state pair
	function automatic stateAddr_t stateAddrOf(input int series, input int harmonic);
		stateAddr_t addr;
		addr = stateAddr_t'(series * (2 ** harmW) + harmonic);
		return addr;
	endfunction

endpackage

// File: pipeDelay.sv
`timescale 1ns/1ps

module pipeDelay #(
	parameter type payload_t = logic,
	parameter int depth = 1
) (
	input  logic clk_i,
	input  logic harmonics_rst,
	input  payload_t in_i,
	output payload_t out_o
);

	payload_t stages [depth];

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			for (int i = 0; i < depth; i++) begin
				stages[i] <= '0;
			end
		end else begin
			stages[0] <= in_i;
			for (int i = 1; i < depth; i++) begin
				stages[i] <= stages[i-1];
			end
		end
	end

	assign out_o = stages[depth-1];

endmodule

// File: harmonicRam.sv
`timescale 1ns/1ps

module harmonicRam #(
	parameter int addrWidth = 9
) (
	input  logic clk_i,
	input  logic we_i,
	input  logic [addrWidth-1:0] wrAddr_i,
	input  harmonics_pkg::pair_t wrData_i,
	input  logic [addrWidth-1:0] rdAddr_i,
	output harmonics_pkg::pair_t rdData_o
);
	import harmonics_pkg::*;

	pair_t mem [2**addrWidth];

	// every state starts from zero
	initial begin
		for (int i = 0; i < 2**addrWidth; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (we_i) begin
			mem[wrAddr_i] <= wrData_i;
		end
	end

	// read data one cycle after the address
	always_ff @(posedge clk_i) begin
		rdData_o <= mem[rdAddr_i];
	end

endmodule

// File: harmonicSequencer.sv
`timescale 1ns/1ps
`include "harmonics_macros.svh"

module harmonicSequencer (
	input  logic clk_i,
	input  logic harmonics_rst,
	input  logic start_i,
	output logic busy_o,
	output harmonics_pkg::stateAddr_t stateRdAddr_o,
	output harmonics_pkg::coefAddr_t coefRdAddr_o,
	output harmonics_pkg::microOp_t op_o
);
	import harmonics_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// step map of one series
	//   stepRotate            one rotate per harmonic
	//   1 .. DRAIN            idle
	//   stepError             error op
	//   next DRAIN steps      idle
	//   stepCorrect           one correct per harmonic
	//   stepTail .. stepLast  idle after the last series only

	localparam int stepRotate = 0;
	localparam int stepError = `DRAIN_STEPS + 1;
	localparam int stepCorrect = 2 * `DRAIN_STEPS + 2;
	localparam int stepTail = stepCorrect + 1;
	localparam int stepLast = stepTail + `DRAIN_STEPS - 1;
	localparam int stepW = $clog2(stepLast + 1);

	logic [stepW-1:0] step;
	logic [harmW-1:0] harm;
	logic [serW-1:0] series;
	logic harmEnd;
	logic seriesEnd;
	logic [1:0] coefOffset;
	coefAddr_t coefBase;

	assign harmEnd = harm == harmW'(`HARMONICS_NUM - 1);
	assign seriesEnd = series == serW'(`SERIES_NUM - 1);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// counters

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			busy_o <= 1'b0;
			step <= '0;
			harm <= '0;
			series <= '0;
		end else if (!busy_o) begin
			// start while busy never reaches here
			if (start_i) begin
				busy_o <= 1'b1;
				step <= '0;
				harm <= '0;
				series <= '0;
			end
		end else if (step == stepW'(stepRotate)) begin
			if (harmEnd) begin
				harm <= '0;
				step <= step + 1'b1;
			end else begin
				harm <= harm + 1'b1;
			end
		end else if (step == stepW'(stepCorrect)) begin
			if (!harmEnd) begin
				harm <= harm + 1'b1;
			end else if (seriesEnd) begin
				harm <= '0;
				step <= step + 1'b1;
			end else begin
				// back to the top of the loop for the next series
				harm <= '0;
				series <= series + 1'b1;
				step <= stepW'(stepRotate);
			end
		end else if (step == stepW'(stepLast)) begin
			busy_o <= 1'b0;
			step <= '0;
		end else begin
			step <= step + 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// addresses and issued op

	// rotation pair at 2k, gain pair at 2k+1
	assign coefBase = coefAddr_t'(2 * int'(harm));

	always_comb begin
		coefOffset = 2'd0;
		op_o.op = opIdle;
		op_o.wrAddr = stateAddrOf(int'(series), int'(harm));
		stateRdAddr_o = stateAddrOf(int'(series), int'(harm));
		if (busy_o) begin
			if (step == stepW'(stepRotate)) begin
				op_o.op = opRotate;
			end else if (step == stepW'(stepError)) begin
				op_o.op = opError;
			end else if (step == stepW'(stepCorrect)) begin
				op_o.op = opCorrect;
				coefOffset = 2'd1;
			end
		end
		if (op_o.op == opError) begin
			coefRdAddr_o = coefAddr_t'(`COEF_INPUT_BASE + int'(series));
		end else begin
			coefRdAddr_o = coefBase + coefAddr_t'(coefOffset);
		end
	end

endmodule

// File: harmonicMac.sv
`timescale 1ns/1ps
`include "harmonics_macros.svh"

module harmonicMac (
	input  logic clk_i,
	input  logic harmonics_rst,
	input  harmonics_pkg::microOp_t op_i,
	input  harmonics_pkg::pair_t state_i,
	input  harmonics_pkg::pair_t coef_i,
	output logic stateWe_o,
	output harmonics_pkg::stateAddr_t stateAddr_o,
	output harmonics_pkg::pair_t stateData_o,
	output logic errValid_o,
	output harmonics_pkg::sample_t err_o
);
	import harmonics_pkg::*;

	localparam int prodW = 2 * `SAMPLE_W;

	microOp_t opStage2;
	pair_t addendIn;
	pair_t addendStage2;
	logic signed [prodW-1:0] prod0;
	logic signed [prodW-1:0] prod1;
	logic signed [prodW-1:0] prod2;
	logic signed [prodW-1:0] prod3;
	logic signed [prodW:0] rotA;
	logic signed [prodW:0] rotB;
	sample_t newA;
	sample_t newB;
	sample_t corrA;
	sample_t corrB;
	acc_t sum;
	acc_t errWide;
	sample_t errHeld;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 1: products

	// correct reuses the first two multipliers with the held error
	always_ff @(posedge clk_i) begin
		if (op_i.op == opCorrect) begin
			prod0 <= coef_i.a * errHeld;
			prod1 <= coef_i.b * errHeld;
		end else begin
			prod0 <= state_i.a * coef_i.a;
			prod1 <= state_i.b * coef_i.b;
		end
		prod2 <= state_i.a * coef_i.b;
		prod3 <= state_i.b * coef_i.a;
	end

	// error adds to the input sample, correct adds to the old state
	assign addendIn = (op_i.op == opError) ? coef_i : state_i;

	pipeDelay #(.payload_t(microOp_t), .depth(`MAC_DEPTH - 1)) opStage (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.in_i(op_i),
		.out_o(opStage2)
	);

	pipeDelay #(.payload_t(pair_t), .depth(`MAC_DEPTH - 1)) addendStage (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.in_i(addendIn),
		.out_o(addendStage2)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 2: shift, add, truncate

	assign rotA = prod0 - prod1;
	assign rotB = prod2 + prod3;
	assign newA = sample_t'(rotA >>> `FRAC_BITS);
	assign newB = sample_t'(rotB >>> `FRAC_BITS);
	assign corrA = addendStage2.a + sample_t'(prod0 >>> `FRAC_BITS);
	assign corrB = addendStage2.b + sample_t'(prod1 >>> `FRAC_BITS);
	assign errWide = acc_t'(addendStage2.a) - sum;

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			stateWe_o <= 1'b0;
			errValid_o <= 1'b0;
			sum <= '0;
			errHeld <= '0;
		end else begin
			stateWe_o <= (opStage2.op == opRotate) || (opStage2.op == opCorrect);
			errValid_o <= opStage2.op == opError;
			if (opStage2.op == opRotate) begin
				sum <= sum + acc_t'(newA);
			end else if (opStage2.op == opError) begin
				sum <= '0;
				errHeld <= sample_t'(errWide);
			end
		end
	end

	always_ff @(posedge clk_i) begin
		stateAddr_o <= opStage2.wrAddr;
		if (opStage2.op == opCorrect) begin
			stateData_o.a <= corrA;
			stateData_o.b <= corrB;
		end else begin
			stateData_o.a <= newA;
			stateData_o.b <= newB;
		end
	end

	assign err_o = errHeld;

endmodule

// File: kalmanHarmonics.sv
`timescale 1ns/1ps
`include "harmonics_macros.svh"

module kalmanHarmonics (
	input  logic clk_i,
	input  logic harmonics_rst,
	input  logic start_i,
	output logic busy_o,
	input  logic coefWe_i,
	input  harmonics_pkg::coefAddr_t coefAddr_i,
	input  harmonics_pkg::pair_t coefData_i,
	output logic stateWe_o,
	output harmonics_pkg::stateAddr_t stateAddr_o,
	output harmonics_pkg::pair_t stateData_o,
	output logic errValid_o,
	output harmonics_pkg::sample_t err_o
);
	import harmonics_pkg::*;

	stateAddr_t stateRdAddr;
	coefAddr_t coefRdAddr;
	microOp_t issueOp;
	microOp_t alignedOp;
	pair_t stateRdData;
	pair_t coefRdData;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// issue side

	harmonicSequencer sequencer (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.start_i(start_i),
		.busy_o(busy_o),
		.stateRdAddr_o(stateRdAddr),
		.coefRdAddr_o(coefRdAddr),
		.op_o(issueOp)
	);

	// state words come back from the datapath three cycles after issue
	harmonicRam #(.addrWidth(`STATE_AW)) stateRam (
		.clk_i(clk_i),
		.we_i(stateWe_o),
		.wrAddr_i(stateAddr_o),
		.wrData_i(stateData_o),
		.rdAddr_i(stateRdAddr),
		.rdData_o(stateRdData)
	);

	harmonicRam #(.addrWidth(`COEF_AW)) coefRam (
		.clk_i(clk_i),
		.we_i(coefWe_i),
		.wrAddr_i(coefAddr_i),
		.wrData_i(coefData_i),
		.rdAddr_i(coefRdAddr),
		.rdData_o(coefRdData)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// datapath side

	// op waits for the registered read data
	pipeDelay #(.payload_t(microOp_t), .depth(`READ_LATENCY)) opAlign (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.in_i(issueOp),
		.out_o(alignedOp)
	);

	harmonicMac mac (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.op_i(alignedOp),
		.state_i(stateRdData),
		.coef_i(coefRdData),
		.stateWe_o(stateWe_o),
		.stateAddr_o(stateAddr_o),
		.stateData_o(stateData_o),
		.errValid_o(errValid_o),
		.err_o(err_o)
	);

endmodule

// File: kalmanHarmonics_chk.sv
`timescale 1ns/1ps

module kalmanHarmonics_chk (
	input logic clk_i,
	input logic harmonics_rst,
	input logic start_i,
	input logic busy_o,
	input logic stateWe_o,
	input logic errValid_o
);

	// the last write of a run may share its cycle with the fall of busy
	writeInRun: assert property (@(posedge clk_i) disable iff (harmonics_rst)
		stateWe_o |-> busy_o || $past(busy_o))
		else $error("state write outside a run");

	errSingle: assert property (@(posedge clk_i) disable iff (harmonics_rst)
		errValid_o |=> !errValid_o)
		else $error("error valid held longer than one cycle");

	// busy only rises after a start seen while idle
	busyRise: assert property (@(posedge clk_i) disable iff (harmonics_rst)
		$rose(busy_o) |-> $past(start_i))
		else $error("busy rose without a start");

	// a start during the last busy cycle is not held over
	startDropped: assert property (@(posedge clk_i) disable iff (harmonics_rst)
		$past(start_i && busy_o) && !busy_o |=> !busy_o)
		else $error("start while busy restarted the sequencer");

endmodule

bind kalmanHarmonics kalmanHarmonics_chk chk (
	.clk_i(clk_i),
	.harmonics_rst(harmonics_rst),
	.start_i(start_i),
	.busy_o(busy_o),
	.stateWe_o(stateWe_o),
	.errValid_o(errValid_o)
);

// File: kalmanHarmonics_tb.sv
`timescale 1ns/1ps
`include "harmonics_macros.svh"

module kalmanHarmonics_tb;
	import harmonics_pkg::*;

	localparam int harmBits = $clog2(`HARMONICS_NUM);
	localparam int writesPerRun = 2 * `HARMONICS_NUM * `SERIES_NUM;
	localparam int seriesSteps = 2 * `HARMONICS_NUM;
	// issue steps of every series, then the drain of the last writes
	localparam int busyCycles = `SERIES_NUM * (2 * `HARMONICS_NUM + 2 * `DRAIN_STEPS + 1)
		+ `DRAIN_STEPS;
	localparam int testCount = 6;
	localparam int runCycles = `SERIES_NUM * (4 * `HARMONICS_NUM + 10) + 100;
	localparam int watchdogCycles = testCount * `SERIES_NUM * (4 * `HARMONICS_NUM + 10) + 100;

	logic clk_i;
	logic harmonics_rst;
	logic start_i;
	logic busy_o;
	logic coefWe_i;
	coefAddr_t coefAddr_i;
	pair_t coefData_i;
	logic stateWe_o;
	stateAddr_t stateAddr_o;
	pair_t stateData_o;
	logic errValid_o;
	sample_t err_o;

	int seed = 32'h5fa6a328;
	int mismatchCount;
	int otherCount;

	// reference model memories
	pair_t modelCoef [2**`COEF_AW];
	pair_t modelState [`SERIES_NUM][`HARMONICS_NUM];

	stateAddr_t expAddr [$];
	pair_t expData [$];
	sample_t expErr [$];
	stateAddr_t actAddr [$];
	pair_t actData [$];
	sample_t actErr [$];

	kalmanHarmonics kalmanHarmonics_inst (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.start_i(start_i),
		.busy_o(busy_o),
		.coefWe_i(coefWe_i),
		.coefAddr_i(coefAddr_i),
		.coefData_i(coefData_i),
		.stateWe_o(stateWe_o),
		.stateAddr_o(stateAddr_o),
		.stateData_o(stateData_o),
		.errValid_o(errValid_o),
		.err_o(err_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk_i) begin
		if (!harmonics_rst) begin
			if (stateWe_o) begin
				actAddr.push_back(stateAddr_o);
				actData.push_back(stateData_o);
			end
			if (errValid_o) begin
				actErr.push_back(err_o);
			end
		end
	end

	initial begin
		repeat (watchdogCycles) @(posedge clk_i);
		$display("watchdog: the tests did not finish within %0d cycles", watchdogCycles);
		$display("TEST FAIL");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers

	function automatic stateAddr_t slotAddress(input int s, input int k);
		return stateAddr_t'((s << harmBits) + k);
	endfunction

	function automatic sample_t randSample(input int range);
		int r;
		r = $random(seed);
		return sample_t'(r % range);
	endfunction

	task automatic compareState(input string testName, input pair_t expected, input pair_t actual);
		if (actual !== expected) begin
			mismatchCount++;
			$display("Fail %s: state expected {%0d, %0d}, actual {%0d, %0d}",
				testName, expected.a, expected.b, actual.a, actual.b);
		end
	endtask

	task automatic compareAddr(input string testName, input stateAddr_t expected,
		input stateAddr_t actual);
		if (actual !== expected) begin
			mismatchCount++;
			$display("Fail %s: address expected 0x%0h, actual 0x%0h", testName, expected, actual);
		end
	endtask

	task automatic compareErr(input string testName, input sample_t expected, input sample_t actual);
		if (actual !== expected) begin
			mismatchCount++;
			$display("Fail %s: error expected %0d, actual %0d", testName, expected, actual);
		end
	endtask

	task automatic writeCoef(input int addr, input pair_t data);
		@(negedge clk_i);
		coefWe_i = 1'b1;
		coefAddr_i = coefAddr_t'(addr);
		coefData_i = data;
		modelCoef[addr] = data;
		@(negedge clk_i);
		coefWe_i = 1'b0;
	endtask

	task automatic loadRotations();
		pair_t p;
		for (int k = 0; k < `HARMONICS_NUM; k++) begin
			p.a = randSample(40000);
			p.b = randSample(40000);
			writeCoef(2 * k, p);
		end
	endtask

	task automatic loadGains();
		pair_t p;
		for (int k = 0; k < `HARMONICS_NUM; k++) begin
			p.a = randSample(16384);
			p.b = randSample(16384);
			writeCoef(2 * k + 1, p);
		end
	endtask

	task automatic loadInputs();
		pair_t p;
		for (int s = 0; s < `SERIES_NUM; s++) begin
			p.a = randSample(60000);
			p.b = '0;
			writeCoef(`COEF_INPUT_BASE + s, p);
		end
	endtask

	// one run of the estimator, writes queued in issue order
	task automatic predictRun();
		pair_t rot;
		pair_t gain;
		pair_t st;
		acc_t sum;
		sample_t err;
		expAddr.delete();
		expData.delete();
		expErr.delete();
		for (int s = 0; s < `SERIES_NUM; s++) begin
			sum = '0;
			for (int k = 0; k < `HARMONICS_NUM; k++) begin
				rot = modelCoef[2 * k];
				st = modelState[s][k];
				modelState[s][k].a = sample_t'((longint'(st.a) * longint'(rot.a)
					- longint'(st.b) * longint'(rot.b)) >>> `FRAC_BITS);
				modelState[s][k].b = sample_t'((longint'(st.a) * longint'(rot.b)
					+ longint'(st.b) * longint'(rot.a)) >>> `FRAC_BITS);
				expAddr.push_back(slotAddress(s, k));
				expData.push_back(modelState[s][k]);
				sum = sum + acc_t'(modelState[s][k].a);
			end
			err = sample_t'(acc_t'(modelCoef[`COEF_INPUT_BASE + s].a) - sum);
			expErr.push_back(err);
			for (int k = 0; k < `HARMONICS_NUM; k++) begin
				gain = modelCoef[2 * k + 1];
				st = modelState[s][k];
				st.a = st.a + sample_t'((longint'(gain.a) * longint'(err)) >>> `FRAC_BITS);
				st.b = st.b + sample_t'((longint'(gain.b) * longint'(err)) >>> `FRAC_BITS);
				modelState[s][k] = st;
				expAddr.push_back(slotAddress(s, k));
				expData.push_back(st);
			end
		end
	endtask

	// extra start pulse goes out extraStartAt cycles into the run, 0 for none
	task automatic doRun(input string testName, input int extraStartAt);
		int cycles;
		predictRun();
		actAddr.delete();
		actData.delete();
		actErr.delete();
		@(negedge clk_i);
		start_i = 1'b1;
		@(negedge clk_i);
		start_i = 1'b0;
		if (!busy_o) begin
			otherCount++;
			$display("%s: busy_o did not rise after start_i", testName);
		end
		cycles = 0;
		while (busy_o && cycles < runCycles) begin
			@(negedge clk_i);
			cycles++;
			start_i = (cycles == extraStartAt);
		end
		start_i = 1'b0;
		if (busy_o) begin
			otherCount++;
			$display("%s: busy_o still high after %0d cycles", testName, runCycles);
		end
		@(negedge clk_i);
		if (actAddr.size() != expAddr.size() || actErr.size() != expErr.size()) begin
			otherCount++;
			$display("%s: saw %0d state writes and %0d errors, wanted %0d and %0d", testName,
				actAddr.size(), actErr.size(), expAddr.size(), expErr.size());
		end
		for (int i = 0; i < expAddr.size() && i < actAddr.size(); i++) begin
			compareAddr(testName, expAddr[i], actAddr[i]);
			compareState(testName, expData[i], actData[i]);
		end
		for (int i = 0; i < expErr.size() && i < actErr.size(); i++) begin
			compareErr(testName, expErr[i], actErr[i]);
		end
	endtask

	// a run with an ignored start keeps its write count and stays idle after
	task automatic expectStartIgnored(input string testName);
		if (actAddr.size() != writesPerRun || actErr.size() != `SERIES_NUM) begin
			otherCount++;
			$display("%s: a start pulse during the run changed the write count", testName);
		end
		repeat (5) @(negedge clk_i);
		if (busy_o) begin
			otherCount++;
			$display("%s: a new run began without an accepted start_i", testName);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests

	task automatic checkResetState();
		if (busy_o !== 1'b0 || stateWe_o !== 1'b0 || errValid_o !== 1'b0) begin
			otherCount++;
			$display("resetState: busy_o, stateWe_o or errValid_o is not low after reset");
		end
		repeat (20) @(negedge clk_i);
		if (actAddr.size() != 0 || actErr.size() != 0) begin
			otherCount++;
			$display("resetState: state writes or errors appeared without start_i");
		end
	endtask

	task automatic zeroStateRun();
		pair_t zeroPair;
		int idx;
		zeroPair = '0;
		loadRotations();
		loadGains();
		loadInputs();
		doRun("zeroStateRun", 0);
		for (int s = 0; s < `SERIES_NUM; s++) begin
			for (int k = 0; k < `HARMONICS_NUM; k++) begin
				idx = s * seriesSteps + k;
				if (idx < actData.size()) begin
					compareState("zeroStateRun", zeroPair, actData[idx]);
				end
			end
			if (s < actErr.size()) begin
				compareErr("zeroStateRun", modelCoef[`COEF_INPUT_BASE + s].a, actErr[s]);
			end
		end
	endtask

	// with zero state the error is the input, so each correct is gain times input
	task automatic firstCorrectWrites();
		pair_t gain;
		pair_t want;
		sample_t in;
		int idx;
		if (actData.size() != writesPerRun) begin
			otherCount++;
			$display("firstCorrectWrites: the first run did not produce every state write");
			return;
		end
		for (int s = 0; s < `SERIES_NUM; s++) begin
			in = modelCoef[`COEF_INPUT_BASE + s].a;
			for (int k = 0; k < `HARMONICS_NUM; k++) begin
				gain = modelCoef[2 * k + 1];
				want.a = sample_t'((longint'(gain.a) * longint'(in)) >>> `FRAC_BITS);
				want.b = sample_t'((longint'(gain.b) * longint'(in)) >>> `FRAC_BITS);
				idx = s * seriesSteps + `HARMONICS_NUM + k;
				compareAddr("firstCorrectWrites", slotAddress(s, k), actAddr[idx]);
				compareState("firstCorrectWrites", want, actData[idx]);
			end
		end
	endtask

	task automatic randomRotationRun();
		loadRotations();
		doRun("randomRotationRun", 0);
	endtask

	task automatic repeatedRuns();
		for (int r = 0; r < 3; r++) begin
			loadInputs();
			doRun($sformatf("repeatedRun%0d", r), 0);
		end
	endtask

	task automatic startWhileBusy();
		loadInputs();
		doRun("startWhileBusy", 20);
		expectStartIgnored("startWhileBusy");
		// this pulse lands in the last busy cycle
		loadInputs();
		doRun("startAtLastBusy", busyCycles - 1);
		expectStartIgnored("startAtLastBusy");
	endtask

	initial begin
		harmonics_rst = 1'b1;
		start_i = 1'b0;
		coefWe_i = 1'b0;
		coefAddr_i = '0;
		coefData_i = '0;
		mismatchCount = 0;
		otherCount = 0;
		for (int s = 0; s < `SERIES_NUM; s++) begin
			for (int k = 0; k < `HARMONICS_NUM; k++) begin
				modelState[s][k] = '0;
			end
		end
		repeat (4) @(negedge clk_i);
		harmonics_rst = 1'b0;

		checkResetState();
		zeroStateRun();
		firstCorrectWrites();
		randomRotationRun();
		repeatedRuns();
		startWhileBusy();

		$display("errors: %0d value mismatches, %0d other failures", mismatchCount, otherCount);
		if (mismatchCount + otherCount == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+.
harmonics_pkg.sv
pipeDelay.sv
harmonicRam.sv
harmonicSequencer.sv
harmonicMac.sv
kalmanHarmonics.sv
kalmanHarmonics_chk.sv
kalmanHarmonics_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= kalmanHarmonics_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
